// File: hpm_unit.f
source/hpm_pkg.sv
source/hpm_event_capture.sv
source/hpm_counter.sv
source/hpm_csr_port.sv
source/hpm_unit.sv
verif/hpm_unit_props.sv
verif/hpm_unit_tb.sv

// File: source/hpm_counter.sv
// Programmable event counter
// Holds one event-select register and one counter of MHPMCounterWidth bits.
// Counts once per cycle in which any selected event is present

`timescale 1ns/1ps

module hpm_counter import hpm_pkg::*; #(
  parameter int unsigned MHPMCounterWidth = 40
) (
  input  logic           clk,
  input  logic           rst_ni,

  input  hpm_events_t    events_i,
  input  hpm_cnt_wr_t    wr_i,
  output hpm_cnt_state_t state_o
);

  // Bits held in the upper CSR half
  localparam int unsigned HiWidth = MHPMCounterWidth - 32;

  hpm_events_t                 sel_q;
  logic [MHPMCounterWidth-1:0] cnt_q;
  logic [MHPMCounterWidth-1:0] cnt_inc;
  logic [MHPMCounterWidth-1:0] cnt_d;
  logic [NumEvents-1:0]        hits;
  logic                        inc;

  //////////////////////////////
  // Increment
  //////////////////////////////

  // Several matching events in one cycle still count once
  assign hits    = events_i & sel_q;
  assign inc     = |hits;
  assign cnt_inc = cnt_q + MHPMCounterWidth'(inc);

  // A CSR write overrides its own half only.
  // The other half keeps its share of the incremented old value
  always_comb begin
    cnt_d = cnt_inc;
    if (wr_i.lo_we) begin
      cnt_d[31:0] = wr_i.wdata;
    end
    if (wr_i.hi_we) begin
      cnt_d[MHPMCounterWidth-1:32] = wr_i.wdata[HiWidth-1:0];
    end
  end

  //////////////////////////////
  // Registers
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q <= '0;
      cnt_q <= '0;
    end else begin
      if (wr_i.sel_we) begin
        sel_q <= hpm_events_t'(wr_i.wdata[NumEvents-1:0]);
      end
      cnt_q <= cnt_d;
    end
  end

  // Zero extension keeps unimplemented upper bits at zero
  assign state_o.sel   = sel_q;
  assign state_o.value = MaxCounterWidth'(cnt_q);

endmodule

// File: source/hpm_csr_port.sv
// Performance counter CSR port
// Decodes accesses to the mhpmcounter, mhpmcounterh and mhpmevent banks,
// returns read data and turns write, set and clear into counter writes

`timescale 1ns/1ps

module hpm_csr_port import hpm_pkg::*; #(
  parameter int unsigned MHPMCounterNum   = 4,
  parameter int unsigned MHPMCounterWidth = 40
) (
  input  hpm_csr_req_t   csr_req_i,
  input  hpm_cnt_state_t state_i [MHPMCounterNum],
  output hpm_cnt_wr_t    wr_o    [MHPMCounterNum],
  output logic [31:0]    csr_rdata_o,
  output logic           csr_illegal_o
);

  // Implemented bits of the upper half
  localparam logic [31:0] HiMask = 32'((64'd1 << (MHPMCounterWidth - 32)) - 64'd1);

  logic [11:0]    off_lo;
  logic [11:0]    off_hi;
  logic [11:0]    off_sel;
  logic           hit_lo;
  logic           hit_hi;
  logic           hit_sel;
  logic           hit_any;
  logic [11:0]    idx;
  logic           legal;
  logic           do_write;
  hpm_cnt_state_t cur_state;
  logic [31:0]    cur_word;
  logic [31:0]    new_word;
  logic [31:0]    wr_data;

  //////////////////////////////
  // Address decode
  //////////////////////////////

  // Addresses below a base wrap to large offsets and miss the bank
  assign off_lo  = csr_req_i.addr - CsrAddrMhpmcounter3;
  assign off_hi  = csr_req_i.addr - CsrAddrMhpmcounterh3;
  assign off_sel = csr_req_i.addr - CsrAddrMhpmevent3;

  assign hit_lo  = csr_req_i.access && (off_lo < 12'(MaxCounters));
  assign hit_hi  = csr_req_i.access && (off_hi < 12'(MaxCounters));
  assign hit_sel = csr_req_i.access && (off_sel < 12'(MaxCounters));
  assign hit_any = hit_lo | hit_hi | hit_sel;

  assign idx = hit_lo ? off_lo : (hit_hi ? off_hi : off_sel);

  // Reserved slots past the last implemented counter
  assign legal         = hit_any && (idx < 12'(MHPMCounterNum));
  assign csr_illegal_o = hit_any && !legal;

  //////////////////////////////
  // Read path
  //////////////////////////////

  always_comb begin
    cur_state = '0;
    for (int k = 0; k < MHPMCounterNum; k++) begin
      if (idx == 12'(k)) begin
        cur_state = state_i[k];
      end
    end
  end

  always_comb begin
    if (hit_lo) begin
      cur_word = cur_state.value[31:0];
    end else if (hit_hi) begin
      cur_word = cur_state.value[MaxCounterWidth-1:32] & HiMask;
    end else begin
      cur_word = 32'(cur_state.sel);
    end
  end

  assign csr_rdata_o = legal ? cur_word : 32'b0;

  //////////////////////////////
  // Write path
  //////////////////////////////

  // Set and clear work on the current word
  always_comb begin
    unique case (csr_req_i.op)
      CSR_OP_WRITE: new_word = csr_req_i.wdata;
      CSR_OP_SET:   new_word = cur_word | csr_req_i.wdata;
      CSR_OP_CLEAR: new_word = cur_word & ~csr_req_i.wdata;
      default:      new_word = cur_word;
    endcase
  end

  assign wr_data  = hit_hi ? (new_word & HiMask) : new_word;
  assign do_write = legal && (csr_req_i.op != CSR_OP_READ);

  // Exactly one strobe towards the addressed counter
  always_comb begin
    for (int k = 0; k < MHPMCounterNum; k++) begin
      wr_o[k].wdata  = wr_data;
      wr_o[k].lo_we  = do_write && hit_lo && (idx == 12'(k));
      wr_o[k].hi_we  = do_write && hit_hi && (idx == 12'(k));
      wr_o[k].sel_we = do_write && hit_sel && (idx == 12'(k));
    end
  end

endmodule

// File: source/hpm_event_capture.sv
// Performance event capture
// Samples the raw core strobes and the data-bus handshake and registers
// them as one aligned event vector

`timescale 1ns/1ps

module hpm_event_capture import hpm_pkg::*; (
  input  logic        clk,
  input  logic        rst_ni,

  // Pipeline strobes
  input  logic        instr_ret_i,
  input  logic        instr_ret_compressed_i,
  input  logic        imiss_i,
  input  logic        jump_i,
  input  logic        branch_i,
  input  logic        branch_taken_i,

  // Data bus handshake
  input  logic        data_req_i,
  input  logic        data_gnt_i,
  input  logic        data_we_i,

  output hpm_events_t events_o
);

  hpm_events_t events_d;

  // Loads and stores count on an accepted data request only
  always_comb begin
    events_d.instr_ret    = instr_ret_i;
    events_d.instr_ret_c  = instr_ret_compressed_i;
    events_d.imiss        = imiss_i;
    events_d.load         = data_req_i & data_gnt_i & ~data_we_i;
    events_d.store        = data_req_i & data_gnt_i & data_we_i;
    events_d.jump         = jump_i;
    events_d.branch       = branch_i;
    events_d.branch_taken = branch_taken_i;
  end

  // One register stage lines up strobes from different pipeline points
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      events_o <= '0;
    end else begin
      events_o <= events_d;
    end
  end

endmodule

// File: source/hpm_pkg.sv
// Hardware performance monitor shared definitions
// Event vector layout, CSR request and counter write/state bundles,
// and the CSR address map of the three counter banks

package hpm_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  // Number of distinct event kinds in the event vector
  parameter int unsigned NumEvents       = 8;
  // Storage width of a counter value as seen by the CSR port
  parameter int unsigned MaxCounterWidth = 64;
  // Address slots reserved in each bank
  parameter int unsigned MaxCounters     = 29;

  //////////////////////////////
  // CSR address map
  //////////////////////////////

  // Base of each bank, counter k lives at base + k
  parameter logic [11:0] CsrAddrMhpmcounter3  = 12'hB03;
  parameter logic [11:0] CsrAddrMhpmcounterh3 = 12'hB83;
  parameter logic [11:0] CsrAddrMhpmevent3    = 12'h323;

  //////////////////////////////
  // Types
  //////////////////////////////

  // One bit per event kind, MSB first
  typedef struct packed {
    logic instr_ret;
    logic instr_ret_c;
    logic imiss;
    logic load;
    logic store;
    logic jump;
    logic branch;
    logic branch_taken;
  } hpm_events_t;

  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  // Valid whenever access is set
  typedef struct packed {
    logic        access;
    csr_op_e     op;
    logic [11:0] addr;
    logic [31:0] wdata;
  } hpm_csr_req_t;

  // Write strobes towards one counter, wdata is the final value to store
  typedef struct packed {
    logic        sel_we;
    logic        lo_we;
    logic        hi_we;
    logic [31:0] wdata;
  } hpm_cnt_wr_t;

  // Current contents of one counter, value is zero above the counter width
  typedef struct packed {
    hpm_events_t                sel;
    logic [MaxCounterWidth-1:0] value;
  } hpm_cnt_state_t;

endpackage

// File: source/hpm_unit.sv
// Hardware performance monitor top level
// Event capture feeds an array of MHPMCounterNum programmable counters,
// which are read and written through a CSR port

`timescale 1ns/1ps

module hpm_unit import hpm_pkg::*; #(
  parameter int unsigned MHPMCounterNum   = 4,
  parameter int unsigned MHPMCounterWidth = 40
) (
  input  logic         clk,
  input  logic         rst_ni,

  // Raw core strobes
  input  logic         instr_ret_i,
  input  logic         instr_ret_compressed_i,
  input  logic         imiss_i,
  input  logic         jump_i,
  input  logic         branch_i,
  input  logic         branch_taken_i,
  input  logic         data_req_i,
  input  logic         data_gnt_i,
  input  logic         data_we_i,

  // CSR access
  input  hpm_csr_req_t csr_req_i,
  output logic [31:0]  csr_rdata_o,
  output logic         csr_illegal_o
);

  hpm_events_t    events;
  hpm_cnt_wr_t    cnt_wr    [MHPMCounterNum];
  hpm_cnt_state_t cnt_state [MHPMCounterNum];

  //////////////////////////////
  // Event capture
  //////////////////////////////

  hpm_event_capture u_event_capture (
    .clk                    (clk),
    .rst_ni                 (rst_ni),
    .instr_ret_i            (instr_ret_i),
    .instr_ret_compressed_i (instr_ret_compressed_i),
    .imiss_i                (imiss_i),
    .jump_i                 (jump_i),
    .branch_i               (branch_i),
    .branch_taken_i         (branch_taken_i),
    .data_req_i             (data_req_i),
    .data_gnt_i             (data_gnt_i),
    .data_we_i              (data_we_i),
    .events_o               (events)
  );

  //////////////////////////////
  // Counter array
  //////////////////////////////

  for (genvar k = 0; k < MHPMCounterNum; k++) begin : g_counter
    hpm_counter #(
      .MHPMCounterWidth (MHPMCounterWidth)
    ) u_counter (
      .clk      (clk),
      .rst_ni   (rst_ni),
      .events_i (events),
      .wr_i     (cnt_wr[k]),
      .state_o  (cnt_state[k])
    );
  end

  //////////////////////////////
  // CSR port
  //////////////////////////////

  hpm_csr_port #(
    .MHPMCounterNum   (MHPMCounterNum),
    .MHPMCounterWidth (MHPMCounterWidth)
  ) u_csr_port (
    .csr_req_i     (csr_req_i),
    .state_i       (cnt_state),
    .wr_o          (cnt_wr),
    .csr_rdata_o   (csr_rdata_o),
    .csr_illegal_o (csr_illegal_o)
  );

endmodule

// File: verif/hpm_unit_props.sv
// Performance monitor CSR port properties
// Bound to hpm_unit, checks the illegal flag against the request
// and the read data seen while it is raised

`timescale 1ns/1ps

module hpm_unit_props import hpm_pkg::*; (
  input logic         clk,
  input logic         rst_ni,
  input hpm_csr_req_t csr_req_i,
  input logic [31:0]  csr_rdata_o,
  input logic         csr_illegal_o
);

  // Number of property failures so far
  int unsigned fail_count = 0;

  illegal_needs_access: assert property (
    @(posedge clk) disable iff (!rst_ni) csr_illegal_o |-> csr_req_i.access
  ) else begin
    fail_count++;
    $error("csr_illegal_o is high without a CSR access");
  end

  illegal_reads_zero: assert property (
    @(posedge clk) disable iff (!rst_ni) csr_illegal_o |-> (csr_rdata_o == 32'h0)
  ) else begin
    fail_count++;
    $error("csr_rdata_o is not zero on an illegal access");
  end

endmodule

bind hpm_unit hpm_unit_props u_props (
  .clk           (clk),
  .rst_ni        (rst_ni),
  .csr_req_i     (csr_req_i),
  .csr_rdata_o   (csr_rdata_o),
  .csr_illegal_o (csr_illegal_o)
);

// File: verif/hpm_unit_tb.sv
// Hardware performance monitor testbench
// Drives random core strobes and CSR traffic into hpm_unit and checks
// every CSR response against a cycle-accurate model of the counters

`timescale 1ns/1ps

module hpm_unit_tb import hpm_pkg::*; ();

  localparam int unsigned NumCounters  = 4;
  localparam int unsigned CntWidth     = 40;
  localparam int unsigned ClkPeriod    = 40;
  localparam int unsigned ResetCycles  = 8;
  localparam int unsigned RandomCycles = 2000;
  localparam int unsigned Margin       = 50;
  localparam logic [31:0] Seed         = 32'hde96_c862;

  // Cycles used by the test phases, in the order they run
  localparam int unsigned TestCycles = ResetCycles + 3 * NumCounters + 6 * NumCounters
                                     + 12 * NumCounters + NumCounters + RandomCycles
                                     + 3 * (MaxCounters - NumCounters) + 7 * NumCounters;
  localparam int unsigned TimeoutNs  = (TestCycles + Margin) * ClkPeriod;

  localparam int BankLo   = 0;
  localparam int BankHi   = 1;
  localparam int BankSel  = 2;
  localparam int BankNone = 3;

  // Raw strobes as they enter the DUT
  typedef struct packed {
    logic instr_ret;
    logic instr_ret_c;
    logic imiss;
    logic jump;
    logic branch;
    logic branch_taken;
    logic data_req;
    logic data_gnt;
    logic data_we;
  } strobes_t;

  logic         clk;
  logic         rst_ni;
  strobes_t     strobes;
  hpm_csr_req_t csr_req;
  logic [31:0]  csr_rdata;
  logic         csr_illegal;

  // Model state
  hpm_events_t         ev_m;
  hpm_events_t         sel_m [NumCounters];
  logic [CntWidth-1:0] cnt_m [NumCounters];
  strobes_t            strobes_q;
  hpm_csr_req_t        req_q;

  hpm_unit u_hpm_unit (
    .clk                    (clk),
    .rst_ni                 (rst_ni),
    .instr_ret_i            (strobes.instr_ret),
    .instr_ret_compressed_i (strobes.instr_ret_c),
    .imiss_i                (strobes.imiss),
    .jump_i                 (strobes.jump),
    .branch_i               (strobes.branch),
    .branch_taken_i         (strobes.branch_taken),
    .data_req_i             (strobes.data_req),
    .data_gnt_i             (strobes.data_gnt),
    .data_we_i              (strobes.data_we),
    .csr_req_i              (csr_req),
    .csr_rdata_o            (csr_rdata),
    .csr_illegal_o          (csr_illegal)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  initial begin
    #(TimeoutNs);
    $display("Simulation finished: FAIL");
    $fatal(1, "Watchdog timeout, the test did not finish in time");
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic hpm_events_t capture_events(input strobes_t s);
    hpm_events_t e;
    e.instr_ret    = s.instr_ret;
    e.instr_ret_c  = s.instr_ret_c;
    e.imiss        = s.imiss;
    e.load         = s.data_req & s.data_gnt & ~s.data_we;
    e.store        = s.data_req & s.data_gnt & s.data_we;
    e.jump         = s.jump;
    e.branch       = s.branch;
    e.branch_taken = s.branch_taken;
    return e;
  endfunction

  function automatic int decode_bank(input logic [11:0] addr, output int idx);
    idx = 0;
    if (addr >= CsrAddrMhpmcounter3 && addr < CsrAddrMhpmcounter3 + MaxCounters) begin
      idx = int'(addr - CsrAddrMhpmcounter3);
      return BankLo;
    end
    if (addr >= CsrAddrMhpmcounterh3 && addr < CsrAddrMhpmcounterh3 + MaxCounters) begin
      idx = int'(addr - CsrAddrMhpmcounterh3);
      return BankHi;
    end
    if (addr >= CsrAddrMhpmevent3 && addr < CsrAddrMhpmevent3 + MaxCounters) begin
      idx = int'(addr - CsrAddrMhpmevent3);
      return BankSel;
    end
    return BankNone;
  endfunction

  function automatic logic [31:0] model_word(input int bank, input int idx);
    if (idx >= NumCounters) begin
      return 32'h0;
    end
    case (bank)
      BankLo:  return cnt_m[idx][31:0];
      BankHi:  return 32'(cnt_m[idx][CntWidth-1:32]);
      BankSel: return 32'(sel_m[idx]);
      default: return 32'h0;
    endcase
  endfunction

  function automatic logic [31:0] expect_rdata(input hpm_csr_req_t r);
    int idx;
    int bank;
    bank = decode_bank(r.addr, idx);
    if (!r.access) begin
      return 32'h0;
    end
    return model_word(bank, idx);
  endfunction

  function automatic logic expect_illegal(input hpm_csr_req_t r);
    int idx;
    int bank;
    bank = decode_bank(r.addr, idx);
    return r.access && (bank != BankNone) && (idx >= NumCounters);
  endfunction

  // One clock edge of the model, applied to the inputs of the cycle just ended
  task automatic model_update();
    int          idx;
    int          bank;
    logic [31:0] cur;
    logic [31:0] nw;
    bank = decode_bank(req_q.addr, idx);
    cur  = model_word(bank, idx);
    for (int k = 0; k < NumCounters; k++) begin
      if (|(ev_m & sel_m[k])) begin
        cnt_m[k] = cnt_m[k] + 1'b1;
      end
    end
    // Write wins over the increment on its own half
    if (req_q.access && bank != BankNone && idx < NumCounters && req_q.op != CSR_OP_READ) begin
      case (req_q.op)
        CSR_OP_WRITE: nw = req_q.wdata;
        CSR_OP_SET:   nw = cur | req_q.wdata;
        default:      nw = cur & ~req_q.wdata;
      endcase
      case (bank)
        BankLo:  cnt_m[idx][31:0] = nw;
        BankHi:  cnt_m[idx][CntWidth-1:32] = nw[CntWidth-33:0];
        default: sel_m[idx] = hpm_events_t'(nw[7:0]);
      endcase
    end
    ev_m = capture_events(strobes_q);
  endtask

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_rdata(input logic [31:0] expected);
    if (csr_rdata !== expected) begin
      $display("Fail at %0t ns: csr_rdata_o got %h expected %h", $time, csr_rdata, expected);
      $display("Simulation finished: FAIL");
      $fatal(1, "CSR read data mismatch");
    end
  endtask

  task automatic check_illegal(input logic expected);
    if (csr_illegal !== expected) begin
      $display("Fail at %0t ns: csr_illegal_o got %b expected %b", $time, csr_illegal,
               expected);
      $display("Simulation finished: FAIL");
      $fatal(1, "CSR illegal flag mismatch");
    end
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  function automatic hpm_csr_req_t make_req(input csr_op_e op, input int bank, input int idx,
                                            input logic [31:0] wdata);
    hpm_csr_req_t r;
    r.access = 1'b1;
    r.op     = op;
    r.wdata  = wdata;
    case (bank)
      BankLo:  r.addr = CsrAddrMhpmcounter3 + 12'(idx);
      BankHi:  r.addr = CsrAddrMhpmcounterh3 + 12'(idx);
      default: r.addr = CsrAddrMhpmevent3 + 12'(idx);
    endcase
    return r;
  endfunction

  function automatic hpm_csr_req_t random_req();
    hpm_csr_req_t r;
    int           pick;
    int           idx;
    csr_op_e      op;
    pick = $urandom_range(99, 0);
    op   = (pick < 70) ? CSR_OP_READ : csr_op_e'($urandom_range(3, 1));
    if ($urandom_range(9, 0) == 0) begin
      idx = $urandom_range(MaxCounters - 1, NumCounters);
    end else begin
      idx = $urandom_range(NumCounters - 1, 0);
    end
    r = make_req(op, $urandom_range(2, 0), idx, $urandom());
    // A few stray addresses and idle cycles
    if (pick >= 95) begin
      r.addr = 12'($urandom());
    end
    if (pick < 5) begin
      r.access = 1'b0;
    end
    return r;
  endfunction

  // Drive one cycle and check the combinational response mid-cycle
  task automatic run_cycle(input strobes_t s, input hpm_csr_req_t r);
    @(posedge clk);
    model_update();
    strobes   <= s;
    csr_req   <= r;
    strobes_q = s;
    req_q     = r;
    @(negedge clk);
    check_rdata(expect_rdata(r));
    check_illegal(expect_illegal(r));
  endtask

  task automatic csr_cycle(input csr_op_e op, input int bank, input int idx,
                           input logic [31:0] wdata);
    run_cycle('0, make_req(op, bank, idx, wdata));
  endtask

  //////////////////////////////
  // Test phases
  //////////////////////////////

  task automatic read_after_reset();
    for (int k = 0; k < NumCounters; k++) begin
      for (int b = BankLo; b <= BankSel; b++) begin
        csr_cycle(CSR_OP_READ, b, k, 32'h0);
        check_rdata(32'h0);
      end
    end
  endtask

  task automatic write_then_read();
    logic [31:0] wdata;
    logic [31:0] expected;
    for (int k = 0; k < NumCounters; k++) begin
      for (int b = BankLo; b <= BankSel; b++) begin
        wdata = $urandom();
        case (b)
          BankLo:  expected = wdata;
          BankHi:  expected = wdata & ~(32'hffff_ffff << (CntWidth - 32));
          default: expected = {24'h0, wdata[7:0]};
        endcase
        csr_cycle(CSR_OP_WRITE, b, k, wdata);
        csr_cycle(CSR_OP_READ, b, k, 32'h0);
        // Select is still zero here, so the counter holds the written value
        check_rdata(expected);
      end
    end
  endtask

  task automatic set_and_clear();
    for (int k = 0; k < NumCounters; k++) begin
      for (int b = BankLo; b <= BankSel; b++) begin
        csr_cycle(CSR_OP_SET, b, k, $urandom());
        csr_cycle(CSR_OP_READ, b, k, 32'h0);
        csr_cycle(CSR_OP_CLEAR, b, k, $urandom());
        csr_cycle(CSR_OP_READ, b, k, 32'h0);
      end
    end
  endtask

  task automatic random_traffic();
    logic [8:0] bits;
    strobes_t   s;
    for (int k = 0; k < NumCounters; k++) begin
      csr_cycle(CSR_OP_WRITE, BankSel, k, $urandom_range(255, 1));
    end
    for (int i = 0; i < RandomCycles; i++) begin
      bits = 9'($urandom_range(511, 0));
      s    = bits;
      run_cycle(s, random_req());
    end
  endtask

  task automatic unimplemented_access();
    for (int b = BankLo; b <= BankSel; b++) begin
      for (int k = NumCounters; k < MaxCounters; k++) begin
        csr_cycle(csr_op_e'($urandom_range(3, 0)), b, k, $urandom());
        check_illegal(1'b1);
        check_rdata(32'h0);
      end
    end
  endtask

  // All-ones plus one retired instruction rolls over to zero
  task automatic counter_wrap();
    strobes_t s;
    for (int k = 0; k < NumCounters; k++) begin
      s           = '0;
      s.instr_ret = 1'b1;
      csr_cycle(CSR_OP_WRITE, BankSel, k, 32'h80);
      csr_cycle(CSR_OP_WRITE, BankLo, k, 32'hffff_ffff);
      csr_cycle(CSR_OP_WRITE, BankHi, k, 32'hffff_ffff);
      run_cycle(s, '0);
      run_cycle('0, '0);
      csr_cycle(CSR_OP_READ, BankLo, k, 32'h0);
      check_rdata(32'h0);
      csr_cycle(CSR_OP_READ, BankHi, k, 32'h0);
      check_rdata(32'h0);
    end
  endtask

  initial begin
    rst_ni    = 1'b0;
    strobes   = '0;
    csr_req   = '0;
    strobes_q = '0;
    req_q     = '0;
    ev_m      = '0;
    for (int k = 0; k < NumCounters; k++) begin
      sel_m[k] = '0;
      cnt_m[k] = '0;
    end
    void'($urandom(Seed));
    repeat (ResetCycles) @(posedge clk);
    rst_ni <= 1'b1;

    read_after_reset();
    write_then_read();
    set_and_clear();
    random_traffic();
    unimplemented_access();
    counter_wrap();
    repeat (2) @(posedge clk);

    if (u_hpm_unit.u_props.fail_count == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      $display("Simulation finished: FAIL");
      $fatal(1, "Concurrent property checks failed during the run");
    end
  end

endmodule
